// File: verilog/fpFormatPkg.sv
// Single and double sit in the low operand bits, extended uses all 80 bits in x87 layout.
package fpFormatPkg;

  localparam int OP_W  = 80;  // Widest operand, extended
  localparam int EXP_W = 16;  // Internal exponent width
  localparam int SIG_W = 64;  // Significand with explicit leading bit

  localparam int SNG_EXP_W  = 8;
  localparam int SNG_FRAC_W = 23;
  localparam int DBL_EXP_W  = 11;
  localparam int DBL_FRAC_W = 52;
  localparam int EXT_EXP_W  = 15;

  typedef enum logic [1:0] {
    fmtSingle   = 2'd0,
    fmtDouble   = 2'd1,
    fmtExtended = 2'd2,
    fmtVerbatim = 2'd3   // Raw 64-bit payload, no conversion
  } fpFmtE;

  localparam logic [EXP_W-1:0] EXP_BIAS = 16'h7fff;   // Common internal bias
  localparam logic [EXP_W-1:0] SNG_BIAS = 16'd127;
  localparam logic [EXP_W-1:0] DBL_BIAS = 16'd1023;
  localparam logic [EXP_W-1:0] EXT_BIAS = 16'd16383;  // Bias of the 15-bit x87 field

  // Operand after format decode, every format on one exponent scale
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;       // Zero for zeros and denormals
    logic [SIG_W-1:0] sig;       // Leading bit at the top
    logic             verbatim;
  } unpackedOpT;

endpackage

// File: verilog/cvtPipePkg.sv
// Credit depths here size both loops; IN_CREDITS must cover the stage-1 item plus the queue.
package cvtPipePkg;

  import fpFormatPkg::*;

  localparam int INT_W   = 64;  // Result width
  localparam int INT32_W = 32;  // Narrow target width

  localparam int IN_CREDITS  = 4;  // Requests the converter can hold
  localparam int OUT_CREDITS = 2;  // Consumer buffer depth

  localparam int Q_PTR_W  = $clog2(IN_CREDITS);
  localparam int Q_CNT_W  = $clog2(IN_CREDITS + 1);
  localparam int OC_CNT_W = $clog2(OUT_CREDITS + 1);
  localparam int SHIFT_W  = $clog2(INT_W);  // Right shift amount 0..63

  typedef struct packed {
    fpFmtE           fmt;
    logic            is32b;    // Target is a 32-bit integer
    logic [OP_W-1:0] operand;
  } cvtReqT;

  typedef enum logic [1:0] {
    rangeInside = 2'd0,
    rangeOver   = 2'd1,  // Saturate, or verbatim payload
    rangeUnder  = 2'd2   // Magnitude below one
  } rangeClassE;

  // Stage-1 item after the fine shift
  typedef struct packed {
    logic [INT_W-1:0] value;
    logic             sign;
    logic             is32b;
  } alignedT;

endpackage

// File: verilog/fpUnpack.sv
// Purely combinational; negative zero is decoded as positive zero, denormals keep their sign.
`timescale 1ns/1ns

module fpUnpack import fpFormatPkg::*, cvtPipePkg::*; (
  input  cvtReqT     req,
  output unpackedOpT op
);

  logic [SNG_EXP_W-1:0]  sngExp;
  logic [SNG_FRAC_W-1:0] sngFrac;
  logic [DBL_EXP_W-1:0]  dblExp;
  logic [DBL_FRAC_W-1:0] dblFrac;
  logic [EXT_EXP_W-1:0]  extExp;

  assign sngExp  = req.operand[SNG_FRAC_W +: SNG_EXP_W];
  assign sngFrac = req.operand[SNG_FRAC_W-1:0];
  assign dblExp  = req.operand[DBL_FRAC_W +: DBL_EXP_W];
  assign dblFrac = req.operand[DBL_FRAC_W-1:0];
  assign extExp  = req.operand[SIG_W +: EXT_EXP_W];

  always_comb begin
    op = '0;
    case (req.fmt)
      fmtSingle: begin
        op.sign = req.operand[SNG_FRAC_W + SNG_EXP_W];
        op.exp  = (sngExp == '0) ? '0 : EXP_W'(sngExp) + (EXP_BIAS - SNG_BIAS);
        op.sig  = {|sngExp, sngFrac, {(SIG_W - 1 - SNG_FRAC_W){1'b0}}};  // Hidden bit
      end
      fmtDouble: begin
        op.sign = req.operand[DBL_FRAC_W + DBL_EXP_W];
        op.exp  = (dblExp == '0) ? '0 : EXP_W'(dblExp) + (EXP_BIAS - DBL_BIAS);
        op.sig  = {|dblExp, dblFrac, {(SIG_W - 1 - DBL_FRAC_W){1'b0}}};
      end
      fmtExtended: begin
        op.sign = req.operand[OP_W-1];
        op.exp  = (extExp == '0) ? '0 : EXP_W'(extExp) + (EXP_BIAS - EXT_BIAS);
        op.sig  = req.operand[SIG_W-1:0];  // Leading bit is explicit
      end
      default: begin
        // Exponent of 63 leaves the payload unshifted
        op.exp      = EXP_BIAS + EXP_W'(SIG_W - 1);
        op.sig      = req.operand[SIG_W-1:0];
        op.verbatim = 1'b1;
      end
    endcase
    if (op.sig == '0) begin
      op.sign = 1'b0;  // -0 converts to 0
    end
  end

endmodule

// File: verilog/cvtRangeCheck.sv
// Class is loaded only on inValid and holds otherwise; verbatim operands never flag saturation.
`timescale 1ns/1ns

module cvtRangeCheck import fpFormatPkg::*, cvtPipePkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       inValid,
  input  unpackedOpT op,
  input  logic       is32b,
  output rangeClassE rangeClass,
  output logic       sat
);

  logic [EXP_W-1:0] overLimit;
  rangeClassE       classNext;

  // Unbiased exponent of width minus one no longer fits a signed integer
  always_comb begin
    overLimit = EXP_BIAS + (is32b ? EXP_W'(INT32_W - 1) : EXP_W'(INT_W - 1));
    if (op.exp < EXP_BIAS) begin
      classNext = rangeUnder;  // Below one, zeros and denormals too
    end else if (op.exp >= overLimit) begin
      classNext = rangeOver;   // Includes infinity and NaN
    end else begin
      classNext = rangeInside;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rangeClass <= rangeUnder;
      sat        <= 1'b0;
    end else if (inValid) begin
      rangeClass <= classNext;
      sat        <= !op.verbatim && (classNext == rangeOver);
    end
  end

endmodule

// File: verilog/cvtAlignShift.sv
// Result is the floor of the operand; value is only meaningful for inside-range and verbatim items.
`timescale 1ns/1ns

module cvtAlignShift import fpFormatPkg::*, cvtPipePkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       inValid,
  input  unpackedOpT op,
  input  logic       is32b,
  output logic       outValid,
  output alignedT    aligned
);

  logic [SIG_W-1:0]   sigTwos;
  logic signed [SIG_W:0] fullVal;    // Sign bit on top of the magnitude
  logic signed [SIG_W:0] coarseVal;
  logic [EXP_W-1:0]   unbiased;
  logic [SHIFT_W-1:0] shAmt;

  logic signed [SIG_W:0] coarseQ;
  logic [2:0]         fineQ;
  logic               signQ;
  logic               is32bQ;
  logic signed [SIG_W:0] fineVal;

  // Two's complement so the arithmetic shift rounds toward minus infinity
  assign sigTwos = op.sign ? (~op.sig + 1'b1) : op.sig;
  assign fullVal = {op.sign, sigTwos};

  // Binary point sits 63 places right of the leading bit
  assign unbiased = op.exp - EXP_BIAS;
  assign shAmt    = SHIFT_W'(INT_W - 1) - unbiased[SHIFT_W-1:0];

  // Coarse byte shift before the register
  assign coarseVal = fullVal >>> {shAmt[SHIFT_W-1:3], 3'b000};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;  // Stage-1 item present
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      coarseQ <= coarseVal;
      fineQ   <= shAmt[2:0];
      signQ   <= op.sign;
      is32bQ  <= is32b;
    end
  end

  // Fine shift of 0 to 7 bits after the register
  assign fineVal = coarseQ >>> fineQ;

  always_comb begin
    aligned.value = fineVal[INT_W-1:0];
    aligned.sign  = signQ;
    aligned.is32b = is32bQ;
  end

endmodule

// File: verilog/cvtResultMerge.sv
// Queue depth equals IN_CREDITS; an upstream producer that ignores its credits will overrun it.
`timescale 1ns/1ns

module cvtResultMerge import cvtPipePkg::*; (
  input  logic             clk,
  input  logic             rstN,
  input  logic             inValid,
  input  rangeClassE       rangeClass,
  input  logic             sat,
  input  alignedT          aligned,
  input  logic             resCredit,
  output logic             resValid,
  output logic [INT_W-1:0] res,
  output logic             reqCredit
);

  logic [INT_W-1:0]    widthMask;
  logic [INT_W-1:0]    maxVal;
  logic [INT_W-1:0]    minVal;
  logic [INT_W-1:0]    satVal;
  logic [INT_W-1:0]    underVal;
  logic [INT_W-1:0]    payload;
  logic [INT_W-1:0]    merged;

  logic [INT_W-1:0]    queueMem [IN_CREDITS];
  logic [Q_PTR_W-1:0]  wrPtr;
  logic [Q_PTR_W-1:0]  rdPtr;
  logic [Q_CNT_W-1:0]  qCount;
  logic [OC_CNT_W-1:0] outCredits;
  logic                issue;

  // Constants derived from the target width
  always_comb begin
    widthMask = aligned.is32b ? {{(INT_W - INT32_W){1'b0}}, {INT32_W{1'b1}}} : '1;
    maxVal    = widthMask >> 1;
    minVal    = widthMask & ~maxVal;  // Top bit of the target only
    satVal    = aligned.sign ? minVal : maxVal;
    underVal  = aligned.sign ? widthMask : '0;  // Minus one, zero-extended for 32 bits
    payload   = aligned.value & widthMask;
  end

  always_comb begin
    case (rangeClass)
      rangeUnder: merged = underVal;
      rangeOver:  merged = sat ? satVal : payload;  // Not sat means verbatim
      default:    merged = payload;
    endcase
  end

  // Issue needs a queued result and a consumer slot
  assign issue     = (qCount != '0) && (outCredits != '0);
  assign resValid  = issue;
  assign reqCredit = issue;   // Slot freed as the result leaves
  assign res       = queueMem[rdPtr];

  always_ff @(posedge clk) begin
    if (inValid) begin
      queueMem[wrPtr] <= merged;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      qCount     <= '0;
      outCredits <= OC_CNT_W'(OUT_CREDITS);
    end else begin
      if (inValid) begin
        wrPtr <= (wrPtr == Q_PTR_W'(IN_CREDITS - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (issue) begin
        rdPtr <= (rdPtr == Q_PTR_W'(IN_CREDITS - 1)) ? '0 : rdPtr + 1'b1;
      end
      qCount     <= qCount + Q_CNT_W'(inValid) - Q_CNT_W'(issue);
      outCredits <= outCredits + OC_CNT_W'(resCredit) - OC_CNT_W'(issue);
    end
  end

endmodule

// File: verilog/fpToIntConverter.sv
// Rounds toward minus infinity only, no flags; the requester must hold a credit for each reqValid.
`timescale 1ns/1ns

module fpToIntConverter import fpFormatPkg::*, cvtPipePkg::*; (
  input  logic             clk,
  input  logic             rstN,
  input  logic             reqValid,
  input  cvtReqT           req,
  output logic             reqCredit,
  output logic             resValid,
  output logic [INT_W-1:0] res,
  input  logic             resCredit
);

  unpackedOpT unpacked;
  rangeClassE rangeClass;
  logic       sat;
  logic       alignValid;  // Stage-1 valid
  alignedT    aligned;

  fpUnpack u_fpUnpack (
    .req (req),
    .op  (unpacked)
  );

  // Range check and alignment run side by side on the same edge
  cvtRangeCheck u_cvtRangeCheck (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (reqValid),
    .op         (unpacked),
    .is32b      (req.is32b),
    .rangeClass (rangeClass),
    .sat        (sat)
  );

  cvtAlignShift u_cvtAlignShift (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (reqValid),
    .op       (unpacked),
    .is32b    (req.is32b),
    .outValid (alignValid),
    .aligned  (aligned)
  );

  cvtResultMerge u_cvtResultMerge (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (alignValid),
    .rangeClass (rangeClass),
    .sat        (sat),
    .aligned    (aligned),
    .resCredit  (resCredit),
    .resValid   (resValid),
    .res        (res),
    .reqCredit  (reqCredit)
  );

endmodule

// File: sim/cvtChecker.sv
// Expects results strictly in request order; the consumer starts with OUT_CREDITS free slots.
`timescale 1ns/1ns

module cvtChecker import cvtPipePkg::*; #(
  parameter int NUM_VEC = 1,
  parameter int VEC_W   = 160
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             reqValid,
  input  logic             reqCredit,
  input  logic             resValid,
  input  logic [INT_W-1:0] res,
  input  logic             resCredit,
  input  logic [VEC_W-1:0] vectors [NUM_VEC],
  output int               errCount,
  output int               mismatchCount,
  output int               resultCount
);

  typedef struct packed {
    logic [7:0]  id;
    logic [3:0]  fmt;
    logic [3:0]  is32b;
    logic [79:0] operand;
    logic [63:0] expected;
  } goldenVecT;

  int consumerCredits;  // Free slots in the consumer buffer
  int outstandingReqs;  // Requests not yet credited back

  task automatic compareResult();
    goldenVecT vec;
    vec = vectors[resultCount];
    if (res !== vec.expected) begin
      $display("FAILED test %h: expected %h, actual %h", vec.id, vec.expected, res);
      mismatchCount++;
    end
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      consumerCredits = OUT_CREDITS;
      outstandingReqs = 0;
      errCount        = 0;
      mismatchCount   = 0;
      resultCount     = 0;
      if (resValid || reqCredit) begin
        $display("Converter signalled a result or credit while held in reset at %0t", $time);
        errCount++;
      end
    end else begin
      if (reqCredit) begin
        if (outstandingReqs == 0) begin
          $display("Converter returned more request credits than requests were sent, at %0t",
                   $time);
          errCount++;
        end else begin
          outstandingReqs--;
        end
      end
      if (reqValid) begin
        outstandingReqs++;
      end
      if (reqCredit != resValid) begin
        $display("Request credit and result valid did not pulse in the same cycle at %0t", $time);
        errCount++;
      end
      if (resValid) begin
        if (consumerCredits == 0) begin
          $display("Result issued while the consumer had no free slot at %0t", $time);
          errCount++;
        end else begin
          consumerCredits--;
        end
        if (resultCount >= NUM_VEC) begin
          $display("Result %h arrived with no request left to match it", res);
          errCount++;
        end else begin
          compareResult();
        end
        resultCount++;
      end
      if (resCredit) begin
        consumerCredits++;  // Slot freed by the consumer
      end
    end
  end

endmodule

// File: sim/tbTop.sv
// NUM_VEC must match the number of vector lines in sim/cvtGolden.hex; run from the project root.
`timescale 1ns/1ns

module tbTop import fpFormatPkg::*, cvtPipePkg::*; ();

  localparam int NUM_VEC        = 31;
  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = 20 * NUM_VEC + 100;
  localparam int MAX_DELAY      = 4;  // Consumer holds a slot 1 to 4 cycles

  typedef struct packed {
    logic [7:0]  id;
    logic [3:0]  fmt;
    logic [3:0]  is32b;
    logic [79:0] operand;
    logic [63:0] expected;
  } goldenVecT;

  logic             clk;
  logic             rstN;
  logic             reqValid;
  cvtReqT           req;
  logic             reqCredit;
  logic             resValid;
  logic [INT_W-1:0] res;
  logic             resCredit;

  logic [$bits(goldenVecT)-1:0] vectors [NUM_VEC];

  int cycleCount = 0;
  int sentCount;
  int driverCredits;   // Upstream credits held by the driver
  int creditDue [$];   // Cycles at which consumer slots free up
  int errCount;
  int mismatchCount;
  int resultCount;

  fpToIntConverter u_fpToIntConverter (
    .clk       (clk),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .req       (req),
    .reqCredit (reqCredit),
    .resValid  (resValid),
    .res       (res),
    .resCredit (resCredit)
  );

  cvtChecker #(
    .NUM_VEC (NUM_VEC),
    .VEC_W   ($bits(goldenVecT))
  ) u_cvtChecker (
    .clk           (clk),
    .rstN          (rstN),
    .reqValid      (reqValid),
    .reqCredit     (reqCredit),
    .resValid      (resValid),
    .res           (res),
    .resCredit     (resCredit),
    .vectors       (vectors),
    .errCount      (errCount),
    .mismatchCount (mismatchCount),
    .resultCount   (resultCount)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic printCounts();
    $display("Summary: %0d errors, %0d mismatches, %0d of %0d results checked",
             errCount, mismatchCount, resultCount, NUM_VEC);
  endtask

  // One falling-edge step of both the request driver and the consumer
  task automatic driveInputs();
    goldenVecT vec;
    reqValid  = 1'b0;
    resCredit = 1'b0;
    if (reqCredit) begin
      driverCredits++;
    end
    if (resValid) begin
      creditDue.push_back(cycleCount + 1 + int'($urandom % MAX_DELAY));
    end
    if (creditDue.size() > 0 && creditDue[0] <= cycleCount) begin
      void'(creditDue.pop_front());
      resCredit = 1'b1;
    end
    if (sentCount < NUM_VEC && driverCredits > 0 && ($urandom % 4) != 0) begin
      vec         = vectors[sentCount];
      req.fmt     = fpFmtE'(vec.fmt[1:0]);
      req.is32b   = vec.is32b[0];
      req.operand = vec.operand;
      reqValid    = 1'b1;
      driverCredits--;
      sentCount++;
    end
  endtask

  initial begin
    rstN          = 1'b0;
    reqValid      = 1'b0;
    req           = '0;
    resCredit     = 1'b0;
    sentCount     = 0;
    driverCredits = IN_CREDITS;
    void'($urandom(32'h94b59fb7));
    $readmemh("sim/cvtGolden.hex", vectors);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    while (resultCount < NUM_VEC) begin
      @(negedge clk);
      driveInputs();
    end
    reqValid  = 1'b0;
    resCredit = 1'b0;
    repeat (4) @(negedge clk);  // Catch any stray extra result
    printCounts();
    if (errCount == 0 && mismatchCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles before all results arrived", cycleCount);
      printCounts();
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

// File: project.f
verilog/fpFormatPkg.sv
verilog/cvtPipePkg.sv
verilog/fpUnpack.sv
verilog/cvtRangeCheck.sv
verilog/cvtAlignShift.sv
verilog/cvtResultMerge.sv
verilog/fpToIntConverter.sv
sim/cvtChecker.sv
sim/tbTop.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tbTop
FILELIST   = project.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the run printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/cvtGolden.hex
// id _ fmt (0 single, 1 double, 2 extended, 3 verbatim) _ is32b _ operand (80 bits) _ expected
// Single and double operands sit in the low operand bits
01_0_0_0000000000003f800000_0000000000000001
02_0_0_000000000000c0200000_fffffffffffffffd
03_0_1_000000000000c0200000_00000000fffffffd
04_0_0_00000000000042c98000_0000000000000064
05_0_0_000000000000c2c98000_ffffffffffffff9b
06_1_0_00004008000000000000_0000000000000003
07_1_0_0000bfe0000000000000_ffffffffffffffff
08_1_1_00003fe8000000000000_0000000000000000
09_1_0_00004270000000000800_0000010000000000
10_1_0_0000c270000000000800_fffffeffffffffff
11_1_1_000041e0000000000000_000000007fffffff
12_1_1_0000c1e0000000000000_0000000080000000
13_1_1_000041d0000000200000_0000000040000000
14_1_1_0000c1d0000000200000_00000000bfffffff
15_0_0_00000000000053800000_0000010000000000
16_0_1_00000000000053800000_000000007fffffff
17_1_0_00007ff0000000000000_7fffffffffffffff
18_1_1_0000fff0000000000000_0000000080000000
19_0_0_0000000000007fc00000_7fffffffffffffff
20_2_0_403e8000000000000000_7fffffffffffffff
21_2_0_c03e8000000000000000_8000000000000000
22_2_0_403dc000000000000001_6000000000000000
23_2_0_c03dc000000000000001_9fffffffffffffff
24_2_1_3fffc000000000000000_0000000000000001
25_2_0_bffe8000000000000000_ffffffffffffffff
26_0_0_00000000000000000001_0000000000000000
27_1_1_00008000000000000000_0000000000000000
28_0_1_000000000000bf400000_00000000ffffffff
29_3_0_12340123456789abcdef_0123456789abcdef
30_3_1_12340123456789abcdef_0000000089abcdef
31_3_0_fffffedcba9876543210_fedcba9876543210
